// File: hdl/sms_io_pkg.sv
//========================================
// Shared widths, counts and types for the
// ROM loader, save backup and audio mixer
//========================================
package sms_io_pkg;

	// ROM download and cartridge addressing
	localparam int ROM_ADDR_W = 22;
	typedef logic [ROM_ADDR_W-1:0] rom_addr_t;

	// Dumped carts may carry a 512 byte copier header
	localparam int HEADER_BYTES = 512;
	localparam logic [5:0] ROM_INDEX = 6'd1;

	// Save RAM and SD sectors
	localparam int NVRAM_ADDR_W = 13;
	typedef logic [NVRAM_ADDR_W-1:0] nvram_addr_t;

	localparam int SECTOR_ADDR_W = 9;
	localparam int BACKUP_SECTORS = 16;
	typedef logic [$clog2(BACKUP_SECTORS)-1:0] blk_t;

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} backup_state_e;

	// FM and PSG audio
	localparam int OPLL_SLOTS = 18;
	typedef logic signed [9:0] opll_sample_t;
	typedef logic signed [15:0] opll_sum_t;
	typedef logic signed [15:0] psg_sample_t;
	typedef logic signed [16:0] audio_mix_t;

endpackage

// File: hdl/sd_buf_if.sv
//========================================
// SD sector buffer port between the
// backup engine and the save RAM
//========================================
`timescale 1ns/1ns

interface sd_buf_if
	import sms_io_pkg::*;
();

	blk_t                     blk;
	logic [SECTOR_ADDR_W-1:0] buf_addr;
	logic                     buf_we;
	logic [7:0]               buf_wdata;
	logic [7:0]               buf_rdata;

	modport engine (output blk, output buf_we);

	modport mem (input blk, input buf_addr, input buf_we, input buf_wdata,
		output buf_rdata);

endinterface

// File: hdl/rom_loader.sv
//========================================
// Cartridge ROM download writer, address
// mask, header detect and console reset
//========================================
`timescale 1ns/1ns

module rom_loader
	import sms_io_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n_i,
	input  logic       ioctl_download_i,
	input  logic       ioctl_wr_i,
	input  logic [7:0] ioctl_index_i,
	input  rom_addr_t  ioctl_addr_i,
	input  logic [7:0] ioctl_dout_i,
	output logic       ioctl_wait_o,
	output logic       rom_wr_o,
	input  logic       rom_wr_ack_i,
	output rom_addr_t  rom_waddr_o,
	output logic [7:0] rom_wdata_o,
	input  rom_addr_t  rom_addr_i,
	output rom_addr_t  rom_raddr_o,
	input  logic       reset_req_i,
	input  logic       bk_reset_i,
	output logic       dl_start_o,
	output logic       console_reset_o
);

	logic      dl_q;
	logic      rom_byte;
	logic      hdr_q;
	rom_addr_t cart_mask_q;

	assign dl_start_o = ioctl_download_i & ~dl_q;
	assign rom_byte   = ioctl_wr_i && (ioctl_index_i[5:0] == ROM_INDEX);

	//========================================
	// Write toggle and back-pressure
	//========================================
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dl_q         <= 1'b0;
			rom_wr_o     <= 1'b0;
			ioctl_wait_o <= 1'b0;
			hdr_q        <= 1'b0;
			cart_mask_q  <= '0;
		end else begin
			dl_q <= ioctl_download_i;
			if (dl_start_o) begin
				cart_mask_q  <= '0;
				ioctl_wait_o <= 1'b0;
			end else if (rom_byte) begin
				ioctl_wait_o <= 1'b1;
				rom_wr_o     <= ~rom_wr_o;
				cart_mask_q  <= cart_mask_q | ioctl_addr_i;
				// Last byte at xx1FF means a copier header
				hdr_q        <= (ioctl_addr_i[9:0] == 10'(HEADER_BYTES - 1));
			end else if (ioctl_wait_o && (rom_wr_o == rom_wr_ack_i)) begin
				ioctl_wait_o <= 1'b0;
			end
		end
	end

	// Address and data held until the toggle is acknowledged
	always_ff @(posedge clk_sys) begin
		if (rom_byte && !dl_start_o) begin
			rom_waddr_o <= ioctl_addr_i;
			rom_wdata_o <= ioctl_dout_i;
		end
	end

	assign rom_raddr_o = (rom_addr_i & cart_mask_q) +
		(hdr_q ? rom_addr_t'(HEADER_BYTES) : rom_addr_t'(0));

	// Console held in reset from power-up
	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			console_reset_o <= 1'b1;
		end else begin
			console_reset_o <= reset_req_i | ioctl_download_i | bk_reset_i;
		end
	end

	// Source must respect wait from the previous write
	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		rom_byte |-> !ioctl_wait_o);

endmodule

// File: hdl/save_backup.sv
//========================================
// Save RAM backup engine, sector load and
// save over the SD request/ack handshake
//========================================
`timescale 1ns/1ns

module save_backup
	import sms_io_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n_i,
	input  logic         dl_start_i,
	input  logic         img_mounted_i,
	input  logic         img_size_nz_i,
	input  logic         save_req_i,
	input  logic         sd_ack_i,
	input  logic         sd_buff_wr_i,
	output blk_t         sd_lba_o,
	output logic         sd_rd_o,
	output logic         sd_wr_o,
	output logic         busy_led_o,
	output logic         bk_reset_o,
	sd_buf_if.engine     sd_bus
);

	backup_state_e state_q;
	blk_t          blk_q;
	logic          bk_ena_q;
	logic          bk_load_q;
	logic          old_load_q;
	logic          old_save_q;
	logic          old_ack_q;
	logic          old_mounted_q;
	logic          ack_rise;
	logic          ack_fall;
	logic          mount_rise;
	logic          start_req;

	assign ack_rise   = sd_ack_i & ~old_ack_q;
	assign ack_fall   = ~sd_ack_i & old_ack_q;
	assign mount_rise = img_mounted_i & ~old_mounted_q & img_size_nz_i;
	assign start_req  = bk_ena_q & ((bk_load_q & ~old_load_q) | (save_req_i & ~old_save_q));

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q       <= BK_IDLE;
			blk_q         <= '0;
			bk_ena_q      <= 1'b0;
			bk_load_q     <= 1'b0;
			old_load_q    <= 1'b0;
			old_save_q    <= 1'b0;
			old_ack_q     <= 1'b0;
			old_mounted_q <= 1'b0;
			sd_rd_o       <= 1'b0;
			sd_wr_o       <= 1'b0;
			bk_reset_o    <= 1'b0;
		end else begin
			bk_reset_o    <= 1'b0;
			old_load_q    <= bk_load_q;
			old_save_q    <= save_req_i;
			old_ack_q     <= sd_ack_i;
			old_mounted_q <= img_mounted_i;

			// New ROM invalidates the current save image
			if (dl_start_i)
				bk_ena_q <= 1'b0;
			if (mount_rise) begin
				bk_ena_q  <= 1'b1;
				bk_load_q <= 1'b1;
			end

			// Host took the request
			if (ack_rise) begin
				sd_rd_o <= 1'b0;
				sd_wr_o <= 1'b0;
			end

			case (state_q)
				BK_IDLE: begin
					if (start_req) begin
						state_q <= BK_XFER;
						blk_q   <= '0;
						sd_rd_o <= bk_load_q;
						sd_wr_o <= ~bk_load_q;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (blk_q == blk_t'(BACKUP_SECTORS - 1)) begin
							bk_reset_o <= bk_load_q;
							bk_load_q  <= 1'b0;
							state_q    <= BK_IDLE;
						end else begin
							blk_q   <= blk_q + 1'b1;
							sd_rd_o <= bk_load_q;
							sd_wr_o <= ~bk_load_q;
						end
					end
				end
				default: state_q <= BK_IDLE;
			endcase
		end
	end

	assign sd_lba_o      = blk_q;
	assign sd_bus.blk    = blk_q;
	// Buffer strobes only count inside an ack window
	assign sd_bus.buf_we = sd_buff_wr_i & sd_ack_i;
	assign busy_led_o    = ~bk_ena_q;

	a_one_request: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		(sd_rd_o || sd_wr_o) |-> (state_q == BK_XFER) && !(sd_rd_o && sd_wr_o));

endmodule

// File: hdl/nvram_buffer.sv
//========================================
// 8 KiB true dual-port save RAM
//========================================
`timescale 1ns/1ns

module nvram_buffer
	import sms_io_pkg::*;
(
	input  logic        clk_sys,
	input  nvram_addr_t cart_addr_i,
	input  logic        cart_we_i,
	input  logic [7:0]  cart_wdata_i,
	output logic [7:0]  cart_rdata_o,
	sd_buf_if.mem       sd_bus
);

	logic [7:0]  mem [2**NVRAM_ADDR_W];
	nvram_addr_t sd_addr;

	// Sector number selects the 512 byte page
	assign sd_addr = {sd_bus.blk, sd_bus.buf_addr};

	// Console port
	always @(posedge clk_sys) begin
		if (cart_we_i)
			mem[cart_addr_i] <= cart_wdata_i;
		cart_rdata_o <= mem[cart_addr_i];
	end

	// SD port
	always @(posedge clk_sys) begin
		if (sd_bus.buf_we)
			mem[sd_addr] <= sd_bus.buf_wdata;
		sd_bus.buf_rdata <= mem[sd_addr];
	end

endmodule

// File: hdl/opll_mixer.sv
//========================================
// OPLL slot accumulation and PSG mix,
// one output sample per 18 slot frame
//========================================
`timescale 1ns/1ns

module opll_mixer
	import sms_io_pkg::*;
(
	input  logic         clk_sys,
	input  logic         rst_n_i,
	input  logic         opll_dac_clk_i,
	input  opll_sample_t opll_mo_i,
	input  opll_sample_t opll_ro_i,
	input  psg_sample_t  psg_i,
	output audio_mix_t   aud_mix_o,
	output logic         aud_valid_o
);

	logic      dac_q1;
	logic      dac_q2;
	logic      dac_rise;
	logic      dac_fall;
	logic      frame_end;
	logic [4:0] slot_q;
	opll_sum_t mo_sum_q;
	opll_sum_t ro_sum_q;

	assign dac_rise  = dac_q1 & ~dac_q2;
	assign dac_fall  = ~dac_q1 & dac_q2;
	assign frame_end = dac_fall && (slot_q == OPLL_SLOTS);

	always_ff @(posedge clk_sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dac_q1      <= 1'b0;
			dac_q2      <= 1'b0;
			slot_q      <= '0;
			mo_sum_q    <= '0;
			ro_sum_q    <= '0;
			aud_valid_o <= 1'b0;
		end else begin
			dac_q1      <= opll_dac_clk_i;
			dac_q2      <= dac_q1;
			aud_valid_o <= frame_end;
			if (dac_rise) begin
				slot_q   <= slot_q + 1'b1;
				mo_sum_q <= mo_sum_q + opll_mo_i;
				ro_sum_q <= ro_sum_q + opll_ro_i;
			end else if (frame_end) begin
				slot_q   <= '0;
				mo_sum_q <= '0;
				ro_sum_q <= '0;
			end
		end
	end

	// Sign extended to the 17 bit mix width
	always_ff @(posedge clk_sys) begin
		if (frame_end)
			aud_mix_o <= mo_sum_q + ro_sum_q + psg_i;
	end

endmodule

// File: hdl/sms_io_top.sv
//========================================
// Console glue top level, ROM loader,
// save backup, save RAM and audio mixer
//========================================
`timescale 1ns/1ns

module sms_io_top
	import sms_io_pkg::*;
(
	input  logic                     clk_sys,
	input  logic                     rst_n_i,
	// ROM download
	input  logic                     ioctl_download_i,
	input  logic                     ioctl_wr_i,
	input  logic [7:0]               ioctl_index_i,
	input  rom_addr_t                ioctl_addr_i,
	input  logic [7:0]               ioctl_dout_i,
	output logic                     ioctl_wait_o,
	output logic                     rom_wr_o,
	input  logic                     rom_wr_ack_i,
	output rom_addr_t                rom_waddr_o,
	output logic [7:0]               rom_wdata_o,
	input  rom_addr_t                rom_addr_i,
	output rom_addr_t                rom_raddr_o,
	input  logic                     reset_req_i,
	output logic                     console_reset_o,
	// SD backup
	input  logic                     img_mounted_i,
	input  logic                     img_size_nz_i,
	input  logic                     save_req_i,
	input  logic                     sd_ack_i,
	input  logic                     sd_buff_wr_i,
	input  logic [SECTOR_ADDR_W-1:0] sd_buff_addr_i,
	input  logic [7:0]               sd_buff_dout_i,
	output logic [7:0]               sd_buff_din_o,
	output blk_t                     sd_lba_o,
	output logic                     sd_rd_o,
	output logic                     sd_wr_o,
	output logic                     busy_led_o,
	// Console save RAM port
	input  nvram_addr_t              cart_addr_i,
	input  logic                     cart_we_i,
	input  logic [7:0]               cart_wdata_i,
	output logic [7:0]               cart_rdata_o,
	// Audio
	input  logic                     opll_dac_clk_i,
	input  opll_sample_t             opll_mo_i,
	input  opll_sample_t             opll_ro_i,
	input  psg_sample_t              psg_i,
	output audio_mix_t               aud_mix_o,
	output logic                     aud_valid_o
);

	logic dl_start;
	logic bk_reset;

	sd_buf_if u_sd_buf ();

	assign u_sd_buf.buf_addr  = sd_buff_addr_i;
	assign u_sd_buf.buf_wdata = sd_buff_dout_i;
	assign sd_buff_din_o      = u_sd_buf.buf_rdata;

	rom_loader u_rom_loader (
		.clk_sys          (clk_sys),
		.rst_n_i          (rst_n_i),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.ioctl_wait_o     (ioctl_wait_o),
		.rom_wr_o         (rom_wr_o),
		.rom_wr_ack_i     (rom_wr_ack_i),
		.rom_waddr_o      (rom_waddr_o),
		.rom_wdata_o      (rom_wdata_o),
		.rom_addr_i       (rom_addr_i),
		.rom_raddr_o      (rom_raddr_o),
		.reset_req_i      (reset_req_i),
		.bk_reset_i       (bk_reset),
		.dl_start_o       (dl_start),
		.console_reset_o  (console_reset_o)
	);

	save_backup u_save_backup (
		.clk_sys       (clk_sys),
		.rst_n_i       (rst_n_i),
		.dl_start_i    (dl_start),
		.img_mounted_i (img_mounted_i),
		.img_size_nz_i (img_size_nz_i),
		.save_req_i    (save_req_i),
		.sd_ack_i      (sd_ack_i),
		.sd_buff_wr_i  (sd_buff_wr_i),
		.sd_lba_o      (sd_lba_o),
		.sd_rd_o       (sd_rd_o),
		.sd_wr_o       (sd_wr_o),
		.busy_led_o    (busy_led_o),
		.bk_reset_o    (bk_reset),
		.sd_bus        (u_sd_buf.engine)
	);

	nvram_buffer u_nvram_buffer (
		.clk_sys      (clk_sys),
		.cart_addr_i  (cart_addr_i),
		.cart_we_i    (cart_we_i),
		.cart_wdata_i (cart_wdata_i),
		.cart_rdata_o (cart_rdata_o),
		.sd_bus       (u_sd_buf.mem)
	);

	opll_mixer u_opll_mixer (
		.clk_sys        (clk_sys),
		.rst_n_i        (rst_n_i),
		.opll_dac_clk_i (opll_dac_clk_i),
		.opll_mo_i      (opll_mo_i),
		.opll_ro_i      (opll_ro_i),
		.psg_i          (psg_i),
		.aud_mix_o      (aud_mix_o),
		.aud_valid_o    (aud_valid_o)
	);

endmodule

// File: bench/tb_clock.sv
//========================================
// Free running system clock, 40 ns period
//========================================
`timescale 1ns/1ns

module tb_clock (
	output logic clk_sys
);

	initial begin
		clk_sys = 1'b0;
		forever #20 clk_sys = ~clk_sys;
	end

endmodule

// File: bench/tb_sms_io.sv
//========================================
// Testbench for the console glue top with
// ROM memory and SD host models
//========================================
`timescale 1ns/1ns

module tb_sms_io
	import sms_io_pkg::*;
();

	logic                     clk_sys;
	logic                     rst_n_i;
	logic                     ioctl_download_i;
	logic                     ioctl_wr_i;
	logic [7:0]               ioctl_index_i;
	rom_addr_t                ioctl_addr_i;
	logic [7:0]               ioctl_dout_i;
	logic                     ioctl_wait_o;
	logic                     rom_wr_o;
	logic                     rom_wr_ack_i;
	rom_addr_t                rom_waddr_o;
	logic [7:0]               rom_wdata_o;
	rom_addr_t                rom_addr_i;
	rom_addr_t                rom_raddr_o;
	logic                     reset_req_i;
	logic                     console_reset_o;
	logic                     img_mounted_i;
	logic                     img_size_nz_i;
	logic                     save_req_i;
	logic                     sd_ack_i;
	logic                     sd_buff_wr_i;
	logic [SECTOR_ADDR_W-1:0] sd_buff_addr_i;
	logic [7:0]               sd_buff_dout_i;
	logic [7:0]               sd_buff_din_o;
	blk_t                     sd_lba_o;
	logic                     sd_rd_o;
	logic                     sd_wr_o;
	logic                     busy_led_o;
	nvram_addr_t              cart_addr_i;
	logic                     cart_we_i;
	logic [7:0]               cart_wdata_i;
	logic [7:0]               cart_rdata_o;
	logic                     opll_dac_clk_i;
	opll_sample_t             opll_mo_i;
	opll_sample_t             opll_ro_i;
	psg_sample_t              psg_i;
	audio_mix_t               aud_mix_o;
	logic                     aud_valid_o;

	// Model state
	logic [7:0] rom_mem [int];
	logic [7:0] rom_exp [int];
	rom_addr_t  rom_mask = '0;
	int         rom_delay = 0;
	logic [7:0] sd_img [2**NVRAM_ADDR_W];
	logic [7:0] cart_img [2**NVRAM_ADDR_W];
	int         sd_cnt = 0;
	int         sd_base = 0;
	int         sd_next_lba = 0;
	logic       sd_is_rd = 1'b0;
	logic       sd_expect_rd = 1'b1;

	tb_clock u_clock (
		.clk_sys (clk_sys)
	);

	sms_io_top u_dut (.*);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string test, input int exp, input int act);
		assert (exp == act)
			else abort_run($sformatf("error %s: expected %0d, actual %0d", test, exp, act));
	endtask

	//========================================
	// Protocol checks
	//========================================
	a_wait_after_wr: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		ioctl_wr_i |=> ioctl_wait_o)
		else abort_run("ioctl_wait_o did not rise after a ROM write");

	a_wait_ends_on_ack: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		$fell(ioctl_wait_o) |-> (rom_wr_o == rom_wr_ack_i))
		else abort_run("ioctl_wait_o fell before the ROM write was acknowledged");

	a_single_sd_req: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		!(sd_rd_o && sd_wr_o))
		else abort_run("sd_rd_o and sd_wr_o were high together");

	a_valid_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n_i)
		aud_valid_o |=> !aud_valid_o)
		else abort_run("aud_valid_o stayed high for more than one cycle");

	//========================================
	// ROM memory and SD host models
	//========================================
	// Each toggle is acknowledged after 1 to 4 cycles
	always @(negedge clk_sys) begin
		if (rom_delay > 0) begin
			rom_delay--;
			if (rom_delay == 0) begin
				rom_mem[rom_waddr_o] = rom_wdata_o;
				rom_wr_ack_i = rom_wr_o;
			end
		end else if (rst_n_i && (rom_wr_o != rom_wr_ack_i)) begin
			rom_delay = $urandom_range(1, 4);
		end
	end

	// One ack window per sector, 512 buffer strobes inside it
	always @(negedge clk_sys) begin
		if (rst_n_i && !sd_ack_i && (sd_rd_o || sd_wr_o)) begin
			check_value("backup_dir", int'(sd_expect_rd), int'(sd_rd_o));
			check_value("backup_lba", sd_next_lba, int'(sd_lba_o));
			sd_next_lba++;
			sd_is_rd = sd_rd_o;
			sd_base  = int'(sd_lba_o) * 512;
			sd_cnt   = 0;
			sd_ack_i = 1'b1;
		end else if (sd_ack_i && (sd_cnt <= 512)) begin
			// Read data lags the address by one cycle
			if ((sd_cnt > 0) && !sd_is_rd)
				check_value("backup_save", int'(cart_img[sd_base + sd_cnt - 1]),
					int'(sd_buff_din_o));
			if (sd_cnt < 512) begin
				sd_buff_addr_i = SECTOR_ADDR_W'(sd_cnt);
				sd_buff_dout_i = sd_img[sd_base + sd_cnt];
				sd_buff_wr_i   = sd_is_rd;
			end else begin
				sd_buff_wr_i = 1'b0;
			end
			sd_cnt++;
		end else if (sd_ack_i) begin
			sd_ack_i = 1'b0;
		end
	end

	//========================================
	// Test tasks
	//========================================
	task automatic download_rom(input int first, input int last);
		int n;
		rom_exp.delete();
		rom_mem.delete();
		rom_mask = '0;
		ioctl_download_i = 1'b1;
		ioctl_index_i    = 8'd1;
		@(negedge clk_sys);
		for (int a = first; a <= last; a++) begin
			ioctl_wr_i   = 1'b1;
			ioctl_addr_i = rom_addr_t'(a);
			ioctl_dout_i = 8'($urandom);
			rom_exp[a]   = ioctl_dout_i;
			rom_mask     = rom_mask | rom_addr_t'(a);
			@(negedge clk_sys);
			ioctl_wr_i = 1'b0;
			n = 0;
			while (ioctl_wait_o) begin
				@(negedge clk_sys);
				n++;
				if (n > 20)
					abort_run("timeout: ioctl_wait_o stayed high after a ROM write");
			end
		end
		ioctl_download_i = 1'b0;
		@(negedge clk_sys);
		foreach (rom_exp[a]) begin
			if (!rom_mem.exists(a))
				abort_run($sformatf("ROM byte at 0x%0h never reached the memory", a));
			check_value("rom_download", int'(rom_exp[a]), int'(rom_mem[a]));
		end
	endtask

	// Header flag comes from the last byte address
	task automatic check_rom_read(input string name, input int last);
		rom_addr_t exp;
		bit        hdr;
		hdr = ((last % 1024) == 511);
		repeat (32) begin
			rom_addr_i = rom_addr_t'($urandom);
			exp = rom_addr_t'((rom_addr_i & rom_mask) + (hdr ? 512 : 0));
			@(posedge clk_sys);
			check_value(name, int'(exp), int'(rom_raddr_o));
			@(negedge clk_sys);
		end
	endtask

	task automatic run_mixer_frame();
		int n;
		int exp;
		psg_i = -16'sd1234;
		exp   = int'(psg_i);
		for (int s = 0; s < 18; s++) begin
			opll_mo_i = opll_sample_t'($urandom_range(0, 200) - 100);
			opll_ro_i = opll_sample_t'($urandom_range(0, 200) - 100);
			exp = exp + int'(opll_mo_i) + int'(opll_ro_i);
			opll_dac_clk_i = 1'b1;
			repeat (3) @(negedge clk_sys);
			opll_dac_clk_i = 1'b0;
			if (s < 17)
				repeat (3) @(negedge clk_sys);
		end
		n = 0;
		while (!aud_valid_o) begin
			@(negedge clk_sys);
			n++;
			if (n > 10)
				abort_run("timeout: aud_valid_o did not pulse at the frame end");
		end
		check_value("mixer", exp, int'(aud_mix_o));
	endtask

	task automatic mount_and_load(input string name);
		int n;
		sd_next_lba   = 0;
		sd_expect_rd  = 1'b1;
		img_size_nz_i = 1'b1;
		img_mounted_i = 1'b1;
		@(negedge clk_sys);
		img_mounted_i = 1'b0;
		check_value({name, "_busy_led"}, 0, int'(busy_led_o));
		n = 0;
		while (!console_reset_o) begin
			@(negedge clk_sys);
			n++;
			if (n > 20000)
				abort_run("timeout: no console reset after the backup load");
		end
		check_value({name, "_sectors"}, 16, sd_next_lba);
		@(negedge clk_sys);
		check_value({name, "_reset_pulse"}, 0, int'(console_reset_o));
	endtask

	task automatic save_sectors();
		int n;
		for (int i = 0; i < 2**NVRAM_ADDR_W; i++) begin
			cart_we_i    = 1'b1;
			cart_addr_i  = nvram_addr_t'(i);
			cart_wdata_i = 8'($urandom);
			cart_img[i]  = cart_wdata_i;
			@(negedge clk_sys);
		end
		cart_we_i    = 1'b0;
		sd_next_lba  = 0;
		sd_expect_rd = 1'b0;
		save_req_i   = 1'b1;
		repeat (2) @(negedge clk_sys);
		save_req_i = 1'b0;
		n = 0;
		while ((sd_next_lba != 16) || sd_ack_i) begin
			@(negedge clk_sys);
			n++;
			if (n > 20000)
				abort_run("timeout: backup save did not finish 16 sectors");
		end
	endtask

	//========================================
	// Main sequence
	//========================================
	initial begin
		void'($urandom(32'h8d48b8ae));
		rst_n_i          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = 8'd0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = 8'd0;
		rom_wr_ack_i     = 1'b0;
		rom_addr_i       = '0;
		reset_req_i      = 1'b0;
		img_mounted_i    = 1'b0;
		img_size_nz_i    = 1'b0;
		save_req_i       = 1'b0;
		sd_ack_i         = 1'b0;
		sd_buff_wr_i     = 1'b0;
		sd_buff_addr_i   = '0;
		sd_buff_dout_i   = 8'd0;
		cart_addr_i      = '0;
		cart_we_i        = 1'b0;
		cart_wdata_i     = 8'd0;
		opll_dac_clk_i   = 1'b0;
		opll_mo_i        = '0;
		opll_ro_i        = '0;
		psg_i            = '0;
		foreach (sd_img[i])
			sd_img[i] = 8'($urandom);

		repeat (5) @(negedge clk_sys);
		check_value("reset_console", 1, int'(console_reset_o));
		check_value("reset_rom_wr", 0, int'(rom_wr_o));
		check_value("reset_wait", 0, int'(ioctl_wait_o));
		check_value("reset_sd_req", 0, int'(sd_rd_o | sd_wr_o));
		check_value("reset_valid", 0, int'(aud_valid_o));
		rst_n_i = 1'b1;
		repeat (2) @(negedge clk_sys);

		// Download with a copier header, then without
		download_rom(0, 'h41FF);
		check_rom_read("rom_mask_hdr", 'h41FF);
		download_rom(0, 'h3FFE);
		check_rom_read("rom_mask_nohdr", 'h3FFE);

		run_mixer_frame();

		mount_and_load("backup_load");
		for (int i = 0; i < 2**NVRAM_ADDR_W; i++) begin
			cart_addr_i = nvram_addr_t'(i);
			@(negedge clk_sys);
			check_value("backup_load_data", int'(sd_img[i]), int'(cart_rdata_o));
		end

		save_sectors();

		// Fresh download drops the backup enable
		check_value("dl_busy_before", 0, int'(busy_led_o));
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		check_value("dl_busy_led", 1, int'(busy_led_o));
		repeat (3) @(negedge clk_sys);
		ioctl_download_i = 1'b0;
		repeat (4) @(negedge clk_sys);
		mount_and_load("remount");

		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: all.f
hdl/sms_io_pkg.sv
hdl/sd_buf_if.sv
hdl/rom_loader.sv
hdl/save_backup.sv
hdl/nvram_buffer.sv
hdl/opll_mixer.sv
hdl/sms_io_top.sv
bench/tb_clock.sv
bench/tb_sms_io.sv
